//--- Makefile
TOP := tb_mem_port

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --timing --top-module mem_port_top -f vlog.f
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

//--- mem_clear.sv
`timescale 1ns/1ps
`default_nettype none

module mem_clear (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           start,
	output logic           busy,
	output logic           we,
	output mem_pkg::addr_t addr
);

	import mem_pkg::*;

	logic last;

	assign last = (addr == addr_t'(MEM_DEPTH - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			addr <= '0;
		end else if (start) begin
			busy <= 1'b1;
			addr <= '0;
		end else if (busy) begin
			addr <= addr + 1'b1; // Wraps back to zero after the last word.
			if (last)
				busy <= 1'b0;
		end
	end

	// One zero word goes out every cycle of the sweep.
	assign we = busy;

	a_no_restart: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
		else $error("mem_clear started while a sweep is still running");

endmodule

`default_nettype wire

//--- mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  mem_pkg::mem_req_t req_data,
	output logic              ack,
	output mem_pkg::mem_rsp_t rsp,
	output logic              clear_start,
	input  logic              clear_busy,
	input  logic              clr_we,
	input  mem_pkg::addr_t    clr_addr,
	output logic              rd_issue,
	input  logic              rd_done,
	input  mem_pkg::word_t    rd_word,
	output logic              ram_en,
	output mem_pkg::addr_t    ram_waddr,
	output mem_pkg::addr_t    ram_raddr,
	output mem_pkg::strobe_t  ram_strobe,
	output mem_pkg::word_t    ram_wdata
);

	import mem_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic        init_pend; // High only in the first cycle after reset.
	logic        host_we;
	logic        take_req;

	assign take_req = (state == IDLE) && req;

	always_comb begin
		state_nxt = state;
		case (state)
			INIT: begin
				if (!init_pend && !clear_busy)
					state_nxt = IDLE;
			end
			IDLE: begin
				if (req) begin
					case (req_data.op)
						OP_READ:  state_nxt = READ_WAIT;
						OP_WRITE: state_nxt = WRITE;
						OP_CLEAR: state_nxt = CLEAR_WAIT;
						default:  state_nxt = ACK_HOLD; // Unknown ops are acked and ignored.
					endcase
				end
			end
			WRITE: state_nxt = ACK_HOLD;
			READ_WAIT: begin
				if (rd_done)
					state_nxt = ACK_HOLD;
			end
			CLEAR_WAIT: begin
				if (!clear_busy)
					state_nxt = ACK_HOLD;
			end
			ACK_HOLD: begin
				if (!req)
					state_nxt = IDLE;
			end
			default: state_nxt = INIT;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= INIT;
			init_pend <= 1'b1;
			ack       <= 1'b0;
			rd_issue  <= 1'b0;
		end else begin
			state     <= state_nxt;
			init_pend <= 1'b0;
			ack       <= (state == ACK_HOLD); // Trails ACK_HOLD by one cycle on both edges.
			rd_issue  <= take_req && (req_data.op == OP_READ);
		end
	end

	// The response only changes when a read returns, so it stays put through ACK_HOLD.
	always_ff @(posedge clk) begin
		if (state == READ_WAIT && rd_done)
			rsp.rdata <= rd_word;
	end

	// The sweep after reset and a host clear both start from here.
	assign clear_start = (state == INIT && init_pend) ||
		(take_req && req_data.op == OP_CLEAR);

	// An empty strobe changes nothing, so the write is skipped.
	assign host_we = (state == WRITE) && (req_data.strobe != '0);

	assign ram_en     = host_we || clr_we;
	assign ram_waddr  = clr_we ? clr_addr : req_data.addr;
	assign ram_strobe = clr_we ? '1 : req_data.strobe;
	assign ram_wdata  = clr_we ? '0 : req_data.wdata;
	assign ram_raddr  = req_data.addr; // Stable for the whole transaction.

	// The host may drop req right after it sees ack, so req is taken at the edge ack rose on.
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	a_single_writer: assert property (@(posedge clk) disable iff (!arst_n)
		!(host_we && clr_we))
		else $error("host write and clear sweep drove the RAM together");

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int MEM_ADDR_W = 10;
	localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;
	localparam int MEM_DATA_W = 64;
	localparam int MEM_BYTE_W = 8;
	localparam int MEM_BYTES  = MEM_DATA_W / MEM_BYTE_W;
	localparam int MEM_RD_LAT = 2; // Cycles from raddr to rdata in the RAM.

	typedef logic [MEM_ADDR_W-1:0] addr_t;
	typedef logic [MEM_DATA_W-1:0] word_t;
	typedef logic [MEM_BYTES-1:0]  strobe_t; // Bit i enables byte i of the word.

	typedef enum logic [1:0] {
		OP_READ  = 2'd0,
		OP_WRITE = 2'd1,
		OP_CLEAR = 2'd2
	} mem_op_e;

	typedef enum logic [2:0] {
		INIT,
		IDLE,
		WRITE,
		READ_WAIT,
		CLEAR_WAIT,
		ACK_HOLD
	} ctrl_state_e;

	// Host request, held stable while req or ack is high.
	typedef struct packed {
		mem_op_e op;
		addr_t   addr;
		strobe_t strobe;
		word_t   wdata;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- mem_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  mem_pkg::mem_req_t req_data,
	output logic              ack,
	output mem_pkg::mem_rsp_t rsp
);

	import mem_pkg::*;

	logic    clear_start;
	logic    clear_busy;
	logic    clr_we;
	addr_t   clr_addr;
	logic    rd_issue;
	logic    rd_done;
	word_t   rd_word;
	logic    ram_en;
	addr_t   ram_waddr;
	addr_t   ram_raddr;
	strobe_t ram_strobe;
	word_t   ram_wdata;
	word_t   ram_rdata;

	mem_ctrl u_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (req),
		.req_data    (req_data),
		.ack         (ack),
		.rsp         (rsp),
		.clear_start (clear_start),
		.clear_busy  (clear_busy),
		.clr_we      (clr_we),
		.clr_addr    (clr_addr),
		.rd_issue    (rd_issue),
		.rd_done     (rd_done),
		.rd_word     (rd_word),
		.ram_en      (ram_en),
		.ram_waddr   (ram_waddr),
		.ram_raddr   (ram_raddr),
		.ram_strobe  (ram_strobe),
		.ram_wdata   (ram_wdata)
	);

	mem_clear u_clear (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (clear_start),
		.busy   (clear_busy),
		.we     (clr_we),
		.addr   (clr_addr)
	);

	// The capture pipe must be as deep as the RAM read path.
	rd_capture #(
		.LATENCY (MEM_RD_LAT)
	) u_capture (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (rd_issue),
		.rdata  (ram_rdata),
		.done   (rd_done),
		.word   (rd_word)
	);

	ram_sdp #(
		.ADDR_WIDTH   (MEM_ADDR_W),
		.DATA_WIDTH   (MEM_DATA_W),
		.BYTE_WIDTH   (MEM_BYTE_W),
		.READ_LATENCY (MEM_RD_LAT)
	) u_ram (
		.clk    (clk),
		.en     (ram_en),
		.raddr  (ram_raddr),
		.waddr  (ram_waddr),
		.strobe (ram_strobe),
		.wdata  (ram_wdata),
		.rdata  (ram_rdata)
	);

endmodule

`default_nettype wire

//--- ram_sdp.sv
`timescale 1ns/1ps
`default_nettype none

module ram_sdp #(
	parameter int ADDR_WIDTH   = 10,
	parameter int DATA_WIDTH   = 64,
	parameter int BYTE_WIDTH   = 8,
	parameter int READ_LATENCY = 1
) (
	input  logic                             clk,
	input  logic                             en,
	input  logic [ADDR_WIDTH-1:0]            raddr,
	input  logic [ADDR_WIDTH-1:0]            waddr,
	input  logic [DATA_WIDTH/BYTE_WIDTH-1:0] strobe,
	input  logic [DATA_WIDTH-1:0]            wdata,
	output logic [DATA_WIDTH-1:0]            rdata
);

	localparam int NUM_WORDS = 2 ** ADDR_WIDTH;
	localparam int BYTES     = DATA_WIDTH / BYTE_WIDTH;

	logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

	// Start from a known array so that simulation never reads X.
	initial begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < BYTES; i++) begin
				if (strobe[i])
					mem[waddr][i*BYTE_WIDTH +: BYTE_WIDTH] <= wdata[i*BYTE_WIDTH +: BYTE_WIDTH];
			end
		end
	end

	if (READ_LATENCY == 0) begin : g_comb_rd
		assign rdata = mem[raddr];
	end else begin : g_reg_rd
		logic [DATA_WIDTH-1:0] rd_q [READ_LATENCY];

		// The first stage samples the array before a same-edge write lands.
		always_ff @(posedge clk) begin
			rd_q[0] <= mem[raddr];
			for (int i = 1; i < READ_LATENCY; i++) begin
				rd_q[i] <= rd_q[i-1];
			end
		end

		assign rdata = rd_q[READ_LATENCY-1];
	end

	// A write cycle with no byte enabled would point at a broken port mux upstream.
	a_strobe_on_write: assert property (@(posedge clk) en |-> (strobe != '0))
		else $error("ram_sdp write with an empty byte strobe");

endmodule

`default_nettype wire

//--- rd_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rd_capture #(
	parameter int LATENCY = 2
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            issue,
	input  mem_pkg::word_t  rdata,
	output logic            done,
	output mem_pkg::word_t  word
);

	import mem_pkg::*;

	localparam int PEND_W = $clog2(LATENCY + 2);

	logic              last;   // Valid bit leaving the pipe, aligned with rdata.
	word_t             hold_q;
	logic [PEND_W-1:0] pend;   // Reads issued and not yet returned.

	if (LATENCY == 0) begin : g_comb
		assign last = issue;
	end else begin : g_pipe
		logic [LATENCY-1:0] vld;

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				vld <= '0;
			end else begin
				vld[0] <= issue;
				for (int i = 1; i < LATENCY; i++) begin
					vld[i] <= vld[i-1];
				end
			end
		end

		assign last = vld[LATENCY-1];
	end

	always_ff @(posedge clk) begin
		if (last)
			hold_q <= rdata;
	end

	assign done = last;
	assign word = last ? rdata : hold_q; // Bypass so the word arrives with done.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pend <= '0;
		else if (issue && !done)
			pend <= pend + 1'b1;
		else if (done && !issue)
			pend <= pend - 1'b1;
	end

	a_done_after_issue: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (pend != '0 || issue))
		else $error("rd_capture returned data that was never requested");

endmodule

`default_nettype wire

//--- tb_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_port;

	import mem_pkg::*;

	localparam int SEED      = 74539;
	localparam int RAND_OPS  = 200;
	localparam int HOLD_EXTRA = 5;
	// Host operations per test, in the order the tests run.
	localparam int N_OPS     = 8 + 16 + 25 + 65 + RAND_OPS + 2;
	localparam int N_CLEARS  = 1 + RAND_OPS / 50;
	localparam int CYCLE_LIMIT = (MEM_DEPTH + 10) * (N_CLEARS + 1) + 20 * N_OPS;

	logic     clk;
	logic     arst_n;
	logic     req;
	mem_req_t req_data;
	logic     ack;
	mem_rsp_t rsp;

	word_t ref_mem [MEM_DEPTH];
	word_t exp_word;
	addr_t cur_addr;
	logic  cur_read;  // High from issue to ack low of a read.
	logic  ack_q;
	logic  req_q;     // Value of req at the last rising edge.
	word_t rsp_q;
	logic  rst_seen;
	int    err_data;
	int    err_hs;
	int    cycles;

	mem_port_top uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.rsp      (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Byte i of the result comes from the new word when strobe bit i is set.
	function automatic word_t merge_write(input word_t old_word, input word_t new_word,
		input strobe_t strb);
		word_t take_mask;
		take_mask = '0;
		for (int i = 0; i < MEM_BYTES; i++)
			take_mask[i*MEM_BYTE_W +: MEM_BYTE_W] = {MEM_BYTE_W{strb[i]}};
		return (old_word & ~take_mask) | (new_word & take_mask);
	endfunction

	function automatic word_t expected_read(input addr_t addr);
		return ref_mem[addr];
	endfunction

	// Entered and left 1 ns after a rising edge.
	task automatic host_op(input mem_op_e op, input addr_t addr, input strobe_t strb,
		input word_t wdata, input int hold);
		cur_read = (op == OP_READ);
		cur_addr = addr;
		if (op == OP_READ)
			exp_word = expected_read(addr);
		req_data.op     = op;
		req_data.addr   = addr;
		req_data.strobe = strb;
		req_data.wdata  = wdata;
		req = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!ack);
		case (op)
			OP_WRITE: ref_mem[addr] = merge_write(ref_mem[addr], wdata, strb);
			OP_CLEAR: begin
				for (int i = 0; i < MEM_DEPTH; i++)
					ref_mem[i] = '0;
			end
			default: ;
		endcase
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (ack);
		cur_read = 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input strobe_t strb, input word_t wdata);
		host_op(OP_WRITE, addr, strb, wdata, 0);
	endtask

	task automatic read_word(input addr_t addr);
		host_op(OP_READ, addr, '0, '0, 0);
	endtask

	task automatic clear_mem();
		host_op(OP_CLEAR, '0, '0, '0, 0);
	endtask

	// Checks the handshake and the read data at the falling edge, where the outputs are settled.
	always @(negedge clk) begin
		if (arst_n) begin
			if (!rst_seen) begin
				assert (ack == 1'b0) else begin
					$display("Handshake error: ack was high right after reset");
					err_hs++;
				end
				rst_seen <= 1'b1;
			end
			if (ack && !ack_q) begin
				assert (req_q) else begin
					$display("Handshake error: ack rose while req was low");
					err_hs++;
				end
				if (cur_read) begin
					assert (rsp.rdata == exp_word) else begin
						$display("FAIL rsp.rdata at addr %h: expected %h, got %h",
							cur_addr, exp_word, rsp.rdata);
						err_data++;
					end
				end
			end
			if (!ack && ack_q) begin
				assert (!req_q) else begin
					$display("Handshake error: ack fell while req was still high");
					err_hs++;
				end
			end
			if (ack && ack_q && cur_read) begin
				assert (rsp.rdata == rsp_q) else begin
					$display("Handshake error: read data changed while ack was held");
					err_hs++;
				end
			end
		end
		ack_q <= ack;
		req_q <= req;
		rsp_q <= rsp.rdata;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		addr_t       a;
		strobe_t     s;
		int unsigned seed_dummy;
		arst_n   = 1'b0;
		req      = 1'b0;
		req_data = '0;
		cur_read = 1'b0;
		cur_addr = '0;
		exp_word = '0;
		ack_q    = 1'b0;
		req_q    = 1'b0;
		rsp_q    = '0;
		rst_seen = 1'b0;
		err_data = 0;
		err_hs   = 0;
		cycles   = 0;
		seed_dummy = $urandom(SEED);
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// The first read is raised while the sweep after reset still runs.
		read_word('0);
		read_word(addr_t'(1));
		read_word(addr_t'(MEM_DEPTH - 1));
		repeat (5)
			read_word(addr_t'($urandom_range(MEM_DEPTH - 1)));

		write_word('0, '1, {$urandom, $urandom});
		read_word('0);
		write_word(addr_t'(MEM_DEPTH - 1), '1, {$urandom, $urandom});
		read_word(addr_t'(MEM_DEPTH - 1));
		repeat (6) begin
			a = addr_t'($urandom_range(MEM_DEPTH - 1));
			write_word(a, '1, {$urandom, $urandom});
			read_word(a);
		end

		// Byte merges over a known base word.
		write_word(addr_t'(10'h155), '1, 64'h0123_4567_89ab_cdef);
		for (int i = 0; i < MEM_BYTES; i++) begin
			write_word(addr_t'(10'h155), strobe_t'(1 << i), {$urandom, $urandom});
			read_word(addr_t'(10'h155));
		end
		write_word(addr_t'(10'h2aa), '1, 64'hfedc_ba98_7654_3210);
		write_word(addr_t'(10'h2aa), strobe_t'(8'h55), {$urandom, $urandom});
		read_word(addr_t'(10'h2aa));
		write_word(addr_t'(10'h2aa), strobe_t'(8'haa), {$urandom, $urandom});
		read_word(addr_t'(10'h2aa));
		write_word(addr_t'(10'h0f0), '1, 64'ha5a5_5a5a_c3c3_3c3c);
		write_word(addr_t'(10'h0f0), strobe_t'(8'h08), 64'd0);
		read_word(addr_t'(10'h0f0));

		// The stride of 33 reaches both the first and the last word.
		for (int i = 0; i < 32; i++)
			write_word(addr_t'(i * 33), '1, {$urandom, $urandom});
		clear_mem();
		for (int i = 0; i < 32; i++)
			read_word(addr_t'(i * 33));

		for (int n = 0; n < RAND_OPS; n++) begin
			a = addr_t'($urandom_range(MEM_DEPTH - 1));
			if (n % 50 == 49) begin
				clear_mem();
			end else if ($urandom_range(1) == 0) begin
				read_word(a);
			end else begin
				s = ($urandom_range(3) == 0) ? '1 : strobe_t'($urandom);
				write_word(a, s, {$urandom, $urandom});
			end
		end

		// A slow host keeps req high past the ack.
		host_op(OP_WRITE, addr_t'(10'h3c3), '1, {$urandom, $urandom}, HOLD_EXTRA);
		host_op(OP_READ, addr_t'(10'h3c3), '0, '0, HOLD_EXTRA);

		repeat (2) @(posedge clk);
		$display("Summary: %0d data errors, %0d handshake errors", err_data, err_hs);
		if (err_data == 0 && err_hs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
mem_pkg.sv
ram_sdp.sv
mem_clear.sv
rd_capture.sv
mem_ctrl.sv
mem_port_top.sv
tb_mem_port.sv
